// File: Bender.yml
package:
  name: rnn_cell

sources:
  # shared package first
  - common/rnn_pkg.sv
  # compute lanes and step sequencer
  - rnn_engine/rnn_dot3.sv
  - rnn_engine/rnn_step_engine.sv
  # loader, serializer and top level
  - verilog/rnn_sample_loader.sv
  - verilog/rnn_out_serializer.sv
  - verilog/rnn_top.sv
  # testbench, model header lives in verif
  - target: test
    include_dirs:
      - verif
    files:
      - verif/rnn_tb.sv

// File: common/rnn_pkg.sv
// shared widths, fixed-point types and bundles for the recurrent cell
package rnn_pkg;

	// --------------------------------------------------------------------------
	// dimensions
	// --------------------------------------------------------------------------

	// vector length and matrix side
	localparam int DIM   = 3;
	// time steps per frame
	localparam int STEPS = 3;

	// fixed-point word
	localparam int FIX_W = 16;
	// six full products plus headroom
	localparam int ACC_W = 36;

	// --------------------------------------------------------------------------
	// data types
	// --------------------------------------------------------------------------

	typedef logic signed [FIX_W-1:0] fix_t;
	typedef logic signed [ACC_W-1:0] acc_t;

	// element 0 sits in the low word
	typedef fix_t [DIM-1:0] vec_t;
	// row-major, m[row][col]
	typedef vec_t [DIM-1:0] mat_t;

	// one input cycle, all four streams together
	typedef struct packed {
		fix_t u;
		fix_t w;
		fix_t v;
		fix_t x;
	} in_sample_t;

	// complete frame as held by the loader
	typedef struct packed {
		mat_t u_m;
		mat_t w_m;
		mat_t v_m;
		// x_seq[t] is input vector x_(t+1)
		vec_t [STEPS-1:0] x_seq;
	} frame_t;

	// --------------------------------------------------------------------------
	// control encodings
	// --------------------------------------------------------------------------

	// engine step sequencer
	typedef enum logic [1:0] {
		IDLE   = 2'd0,
		CALC_H = 2'd1,
		CALC_Y = 2'd2
	} step_state_e;

	// lane post-processing
	typedef enum logic {
		OP_HIDDEN = 1'b0,
		OP_OUTPUT = 1'b1
	} lane_op_e;

endpackage

// File: rnn_engine/rnn_dot3.sv
`timescale 1ns/1ps

// one lane: a_row.a_vec + b_row.b_vec, rescaled and clamped to fix_t
module rnn_dot3 #(
	parameter int FRAC_BITS = 8
) (
	input  rnn_pkg::lane_op_e op,
	input  rnn_pkg::vec_t     a_row,
	input  rnn_pkg::vec_t     a_vec,
	input  rnn_pkg::vec_t     b_row,
	input  rnn_pkg::vec_t     b_vec,
	output rnn_pkg::fix_t     result
);

	// fix_t limits at accumulator width
	localparam rnn_pkg::acc_t SAT_MAX = rnn_pkg::acc_t'(2 ** (rnn_pkg::FIX_W - 1) - 1);
	localparam rnn_pkg::acc_t SAT_MIN = -SAT_MAX - 1;

	rnn_pkg::acc_t acc;
	rnn_pkg::acc_t shifted;
	rnn_pkg::fix_t sat;

	always_comb begin
		// full-precision six-term sum, operands sign-extend to ACC_W
		acc = '0;
		for (int i = 0; i < rnn_pkg::DIM; i++) begin
			acc = acc + a_row[i] * a_vec[i] + b_row[i] * b_vec[i];
		end

		// drop fraction bits, rounds toward minus infinity
		shifted = acc >>> FRAC_BITS;

		// clamp into fix_t range
		if (shifted > SAT_MAX)
			sat = rnn_pkg::fix_t'(SAT_MAX);
		else if (shifted < SAT_MIN)
			sat = rnn_pkg::fix_t'(SAT_MIN);
		else
			sat = rnn_pkg::fix_t'(shifted);

		// relu only on the output phase
		if (op == rnn_pkg::OP_OUTPUT && sat < 0)
			result = '0;
		else
			result = sat;
	end

endmodule

// File: rnn_engine/rnn_step_engine.sv
`timescale 1ns/1ps

// step sequencer
// per time step: one CALC_H cycle, then one CALC_Y cycle
// three lanes, one per matrix row, shared by both phases
module rnn_step_engine #(
	parameter int FRAC_BITS = 8
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             load_done,
	input  rnn_pkg::frame_t  frame,
	output rnn_pkg::vec_t    y_vec,
	output logic             y_valid
);

	localparam int STEP_W = $clog2(rnn_pkg::STEPS);

	// --------------------------------------------------------------------------
	// state machine
	// --------------------------------------------------------------------------

	rnn_pkg::step_state_e state;
	rnn_pkg::step_state_e state_next;
	// current time step, 0 based
	logic [STEP_W-1:0]    step;

	always_comb begin
		state_next = state;
		case (state)
			rnn_pkg::IDLE: begin
				if (load_done)
					state_next = rnn_pkg::CALC_H;
			end
			rnn_pkg::CALC_H: begin
				state_next = rnn_pkg::CALC_Y;
			end
			rnn_pkg::CALC_Y: begin
				// last step goes back to idle
				if (step == STEP_W'(rnn_pkg::STEPS - 1))
					state_next = rnn_pkg::IDLE;
				else
					state_next = rnn_pkg::CALC_H;
			end
			default: state_next = rnn_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= rnn_pkg::IDLE;
			step  <= '0;
		end
		else begin
			state <= state_next;
			if (state == rnn_pkg::IDLE)
				step <= '0;
			else if (state == rnn_pkg::CALC_Y)
				step <= step + 1'b1;
		end
	end

	// --------------------------------------------------------------------------
	// lane operand select
	// --------------------------------------------------------------------------

	rnn_pkg::vec_t     h_reg;
	rnn_pkg::lane_op_e lane_op;
	rnn_pkg::mat_t     lane_a_row;
	rnn_pkg::vec_t     lane_a_vec;
	rnn_pkg::mat_t     lane_b_row;
	rnn_pkg::vec_t     lane_b_vec;
	rnn_pkg::vec_t     lane_res;

	always_comb begin
		lane_op    = rnn_pkg::OP_HIDDEN;
		lane_a_row = '0;
		lane_a_vec = '0;
		lane_b_row = '0;
		lane_b_vec = '0;
		case (state)
			// h_t = U.x_t + W.h_(t-1)
			rnn_pkg::CALC_H: begin
				lane_a_row = frame.u_m;
				lane_a_vec = frame.x_seq[step];
				lane_b_row = frame.w_m;
				lane_b_vec = h_reg;
			end
			// y_t = relu(V.h_t), second product held at zero
			rnn_pkg::CALC_Y: begin
				lane_op    = rnn_pkg::OP_OUTPUT;
				lane_a_row = frame.v_m;
				lane_a_vec = h_reg;
			end
			default: ;
		endcase
	end

	for (genvar r = 0; r < rnn_pkg::DIM; r++) begin : g_lane
		rnn_dot3 #(
			.FRAC_BITS (FRAC_BITS)
		) u_dot3 (
			.op     (lane_op),
			.a_row  (lane_a_row[r]),
			.a_vec  (lane_a_vec),
			.b_row  (lane_b_row[r]),
			.b_vec  (lane_b_vec),
			.result (lane_res[r])
		);
	end

	// --------------------------------------------------------------------------
	// hidden state and result registers
	// --------------------------------------------------------------------------

	// h0 is zero for every new frame
	always_ff @(posedge clk) begin
		if (load_done)
			h_reg <= '0;
		else if (state == rnn_pkg::CALC_H)
			h_reg <= lane_res;
	end

	// y_vec only meaningful alongside y_valid
	always_ff @(posedge clk) begin
		if (state == rnn_pkg::CALC_Y)
			y_vec <= lane_res;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			y_valid <= 1'b0;
		else
			y_valid <= (state == rnn_pkg::CALC_Y);
	end

endmodule

// File: src.f
+incdir+verif
common/rnn_pkg.sv
verilog/rnn_sample_loader.sv
rnn_engine/rnn_dot3.sv
rnn_engine/rnn_step_engine.sv
verilog/rnn_out_serializer.sv
verilog/rnn_top.sv
verif/rnn_tb.sv

// File: verif/rnn_tb_model.svh
`ifndef RNN_TB_MODEL_SVH
`define RNN_TB_MODEL_SVH

// nine input samples, sample 0 in the low word
typedef rnn_pkg::in_sample_t [8:0] frame_smp_t;
// nine expected outputs, y1[0] in the low word
typedef rnn_pkg::fix_t [8:0] burst_t;

// arithmetic shift by frac, then clamp to the fix_t range
function automatic longint rescale_sat(input longint sum, input int frac);
	longint hi;
	longint lo;
	longint s;
	hi = (longint'(1) <<< (rnn_pkg::FIX_W - 1)) - 1;
	lo = -hi - 1;
	s = sum >>> frac;
	if (s > hi)
		s = hi;
	else if (s < lo)
		s = lo;
	return s;
endfunction

// negative values become zero
function automatic longint relu_clip(input longint v);
	return (v < 0) ? 0 : v;
endfunction

// whole frame: three steps of h_t = U.x_t + W.h_(t-1), y_t = relu(V.h_t)
function automatic burst_t model_frame(input frame_smp_t smp, input int frac);
	longint u_m [3][3];
	longint w_m [3][3];
	longint v_m [3][3];
	longint x_m [3][3];
	longint h [3];
	longint h_new [3];
	longint sum;
	burst_t y;
	// sample k is element k of each matrix, row-major
	for (int k = 0; k < 9; k++) begin
		u_m[k/3][k%3] = smp[k].u;
		w_m[k/3][k%3] = smp[k].w;
		v_m[k/3][k%3] = smp[k].v;
		x_m[k/3][k%3] = smp[k].x;
	end
	// h0 is zero
	for (int r = 0; r < 3; r++)
		h[r] = 0;
	for (int t = 0; t < 3; t++) begin
		for (int r = 0; r < 3; r++) begin
			sum = 0;
			for (int c = 0; c < 3; c++)
				sum = sum + u_m[r][c] * x_m[t][c] + w_m[r][c] * h[c];
			h_new[r] = rescale_sat(sum, frac);
		end
		h = h_new;
		for (int r = 0; r < 3; r++) begin
			sum = 0;
			for (int c = 0; c < 3; c++)
				sum = sum + v_m[r][c] * h[c];
			y[t*3 + r] = rnn_pkg::fix_t'(relu_clip(rescale_sat(sum, frac)));
		end
	end
	return y;
endfunction

`endif

// File: verif/rnn_tb.sv
`timescale 1ns/1ps

module rnn_tb;

	localparam int FRAC_BITS  = 8;
	localparam int NUM_FRAMES = 7;
	localparam int FIRST_RAND = 3;
	localparam int SEED       = 32'ha9943f68;

	logic                clk;
	logic                rst_n;
	logic                in_valid;
	rnn_pkg::in_sample_t in_data;
	logic                out_valid;
	rnn_pkg::fix_t       out;

	`include "rnn_tb_model.svh"

	// stimulus and expected bursts, one row per frame
	frame_smp_t  frames  [NUM_FRAMES];
	burst_t      exp_tab [NUM_FRAMES];
	// scratch rows for the hand-written frames
	int          mu [9];
	int          mw [9];
	int          mv [9];
	int          mx [9];
	int          err_value;
	int          err_timing;
	int          err_idle;

	rnn_top #(
		.FRAC_BITS (FRAC_BITS)
	) dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_data   (in_data),
		.out_valid (out_valid),
		.out       (out)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ------------------------------------------------------------------------
	// table setup
	// ------------------------------------------------------------------------

	function automatic rnn_pkg::fix_t rand_word(input int span);
		return rnn_pkg::fix_t'(int'($urandom_range(2 * span, 0)) - span);
	endfunction

	task automatic store_frame(input int fr);
		for (int k = 0; k < 9; k++) begin
			frames[fr][k].u = rnn_pkg::fix_t'(mu[k]);
			frames[fr][k].w = rnn_pkg::fix_t'(mw[k]);
			frames[fr][k].v = rnn_pkg::fix_t'(mv[k]);
			frames[fr][k].x = rnn_pkg::fix_t'(mx[k]);
		end
	endtask

	task automatic build_table();
		int span;
		// identity U and V, no recurrence, outputs equal x
		mu = '{256, 0, 0, 0, 256, 0, 0, 0, 256};
		mw = '{0, 0, 0, 0, 0, 0, 0, 0, 0};
		mv = '{256, 0, 0, 0, 256, 0, 0, 0, 256};
		mx = '{256, 512, 768, 128, 64, 256, 768, 16, 1};
		store_frame(0);
		// recurrent W, x2 zero, negative V row for relu
		mw = '{128, 0, 64, 0, 128, 0, -64, 0, 128};
		mv = '{256, 0, 0, 0, -256, 0, 128, 128, 0};
		mx = '{256, 512, -256, 0, 0, 0, 256, 256, 256};
		store_frame(1);
		// full-scale values, hidden and output clamp
		mu = '{32767, 32767, 32767, 32767, 32767, 32767, 32767, 32767, 32767};
		mw = '{32767, -32768, 32767, 32767, 32767, 32767, -32768, -32768, -32768};
		mv = '{32767, 32767, 32767, -32768, -32768, -32768, 32767, 0, 0};
		mx = '{32767, 32767, 32767, -32768, -32768, -32768, 1000, 1000, 1000};
		store_frame(2);
		// random frames, last one full range
		for (int fr = FIRST_RAND; fr < NUM_FRAMES; fr++) begin
			span = (fr == NUM_FRAMES - 1) ? 32767 : 1024;
			for (int k = 0; k < 9; k++) begin
				frames[fr][k].u = rand_word(span);
				frames[fr][k].w = rand_word(span);
				frames[fr][k].v = rand_word(span);
				frames[fr][k].x = rand_word(span);
			end
		end
		for (int fr = 0; fr < NUM_FRAMES; fr++)
			exp_tab[fr] = model_frame(frames[fr], FRAC_BITS);
	endtask

	// ------------------------------------------------------------------------
	// one frame: load, wait for burst, check timing and values
	// ------------------------------------------------------------------------

	task automatic run_frame(input int fr);
		int  wait_cyc;
		bit  seen;
		for (int k = 0; k < 9; k++) begin
			@(negedge clk);
			in_valid = 1'b1;
			in_data  = frames[fr][k];
		end
		// first low cycle
		@(negedge clk);
		in_valid = 1'b0;
		in_data  = '0;
		wait_cyc = 0;
		seen     = 1'b0;
		while (!seen && wait_cyc < 20) begin
			@(negedge clk);
			wait_cyc++;
			if (out_valid === 1'b1)
				seen = 1'b1;
		end
		if (!seen) begin
			err_timing++;
			$display("Error: frame %0d produced no out_valid within 20 cycles", fr);
		end
		else begin
			if (wait_cyc != 5) begin
				err_timing++;
				$display("Error: time %0t signal out_valid delay expected 5 got %0d",
					$time, wait_cyc);
			end
			for (int k = 0; k < 9; k++) begin
				if (k > 0)
					@(negedge clk);
				if (out_valid !== 1'b1) begin
					err_timing++;
					$display("Error: frame %0d burst ended early at value %0d", fr, k);
				end
				if (out !== exp_tab[fr][k]) begin
					err_value++;
					$display("Error: time %0t signal out expected %0d got %0d (frame %0d value %0d)",
						$time, exp_tab[fr][k], out, fr, k);
				end
			end
			// tenth cycle must be idle again
			@(negedge clk);
			if (out_valid !== 1'b0) begin
				err_timing++;
				$display("Error: frame %0d burst ran longer than nine cycles", fr);
			end
		end
	endtask

	// out held at zero whenever no burst is running
	always @(negedge clk) begin
		if (rst_n === 1'b1 && out_valid !== 1'b1 && out !== '0) begin
			err_idle++;
			$display("Error: time %0t signal out expected 0 got %0d", $time, out);
		end
	end

	// ------------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------------

	initial begin
		err_value  = 0;
		err_timing = 0;
		err_idle   = 0;
		void'($urandom(SEED));
		rst_n      = 1'b0;
		in_valid   = 1'b0;
		in_data    = '0;
		build_table();
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		// quiet after reset, before any frame
		repeat (4) begin
			@(negedge clk);
			if (out_valid !== 1'b0) begin
				err_timing++;
				$display("Error: time %0t signal out_valid expected 0 got %b",
					$time, out_valid);
			end
		end
		for (int fr = 0; fr < NUM_FRAMES; fr++)
			run_frame(fr);
		$display("errors: value %0d, timing %0d, idle %0d", err_value, err_timing, err_idle);
		if (err_value + err_timing + err_idle == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	// about 25 cycles per frame plus reset, with margin
	initial begin
		repeat (NUM_FRAMES * 30 + 50) @(posedge clk);
		$display("watchdog expired before all frames were checked");
		$display("sim failed");
		$finish;
	end

endmodule

// File: verilog/rnn_out_serializer.sv
`timescale 1ns/1ps

// result buffer
// three y values in every other cycle, one value out per cycle
module rnn_out_serializer (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          y_valid,
	input  rnn_pkg::vec_t y_vec,
	output logic          out_valid,
	output rnn_pkg::fix_t out
);

	localparam int BUF_DEPTH = rnn_pkg::DIM * rnn_pkg::STEPS;
	localparam int PTR_W     = $clog2(BUF_DEPTH + 1);

	// --------------------------------------------------------------------------
	// storage
	// --------------------------------------------------------------------------

	rnn_pkg::fix_t    y_buf [BUF_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_cnt;

	// whole vector lands at wr_ptr..wr_ptr+2
	always_ff @(posedge clk) begin
		if (y_valid) begin
			for (int i = 0; i < rnn_pkg::DIM; i++) begin
				y_buf[wr_ptr + i] <= y_vec[i];
			end
		end
	end

	// --------------------------------------------------------------------------
	// pointers and burst control
	// --------------------------------------------------------------------------

	// write pointer wraps after the third vector
	// so it is back at 0 for the next frame
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
		end
		else if (y_valid) begin
			if (wr_ptr == PTR_W'(BUF_DEPTH - rnn_pkg::DIM))
				wr_ptr <= '0;
			else
				wr_ptr <= wr_ptr + PTR_W'(rnn_pkg::DIM);
		end
	end

	// burst starts the cycle after the first y_valid
	// read side trails the writes, never catches up
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			rd_cnt    <= '0;
		end
		else if (y_valid && wr_ptr == '0) begin
			out_valid <= 1'b1;
			rd_cnt    <= '0;
		end
		else if (out_valid) begin
			// ninth value out, rearm
			if (rd_cnt == PTR_W'(BUF_DEPTH - 1)) begin
				out_valid <= 1'b0;
				rd_cnt    <= '0;
			end
			else begin
				rd_cnt <= rd_cnt + 1'b1;
			end
		end
	end

	// zero outside the burst
	assign out = out_valid ? y_buf[rd_cnt] : '0;

endmodule

// File: verilog/rnn_sample_loader.sv
`timescale 1ns/1ps

// frame capture
// nine samples shift in, the first one ends up in the lowest word
module rnn_sample_loader (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                in_valid,
	input  rnn_pkg::in_sample_t in_data,
	output rnn_pkg::frame_t     frame,
	output logic                load_done
);

	// --------------------------------------------------------------------------
	// matrix and vector storage
	// --------------------------------------------------------------------------

	// mat_t as a flat word array: word k is m[k/3][k%3]
	// x_seq likewise: word k is x_(k/3+1)[k%3]
	localparam int MAT_BITS = $bits(rnn_pkg::mat_t);
	localparam int SEQ_BITS = $bits(frame.x_seq);

	// new word enters at the top, older words move down by one
	// the word that falls off the bottom is dropped by the size cast
	always_ff @(posedge clk) begin
		if (in_valid) begin
			frame.u_m   <= MAT_BITS'({in_data.u, frame.u_m} >> rnn_pkg::FIX_W);
			frame.w_m   <= MAT_BITS'({in_data.w, frame.w_m} >> rnn_pkg::FIX_W);
			frame.v_m   <= MAT_BITS'({in_data.v, frame.v_m} >> rnn_pkg::FIX_W);
			frame.x_seq <= SEQ_BITS'({in_data.x, frame.x_seq} >> rnn_pkg::FIX_W);
		end
	end

	// --------------------------------------------------------------------------
	// end-of-frame detect
	// --------------------------------------------------------------------------

	// in_valid one cycle back
	logic prev_valid;

	// falling edge of in_valid seen in cycle L
	// strobe comes out registered in L+1
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prev_valid <= 1'b0;
			load_done  <= 1'b0;
		end
		else begin
			prev_valid <= in_valid;
			load_done  <= prev_valid & ~in_valid;
		end
	end

endmodule

// File: verilog/rnn_top.sv
`timescale 1ns/1ps

// recurrent cell top
// loader -> step engine -> output serializer
module rnn_top #(
	// fractional bits of every fixed-point word
	parameter int FRAC_BITS = 8
) (
	input  logic                clk,
	input  logic                rst_n,
	// input stream, nine cycles per frame
	input  logic                in_valid,
	input  rnn_pkg::in_sample_t in_data,
	// output burst, nine values
	output logic                out_valid,
	output rnn_pkg::fix_t       out
);

	// --------------------------------------------------------------------------
	// internal connections
	// --------------------------------------------------------------------------

	// loader to engine
	rnn_pkg::frame_t frame;
	logic            load_done;

	// engine to serializer
	rnn_pkg::vec_t   y_vec;
	logic            y_valid;

	// --------------------------------------------------------------------------
	// blocks
	// --------------------------------------------------------------------------

	// producer, collects u/w/v/x samples
	rnn_sample_loader u_loader (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_data   (in_data),
		.frame     (frame),
		.load_done (load_done)
	);

	// three time steps, hidden then output per step
	rnn_step_engine #(
		.FRAC_BITS (FRAC_BITS)
	) u_engine (
		.clk       (clk),
		.rst_n     (rst_n),
		.load_done (load_done),
		.frame     (frame),
		.y_vec     (y_vec),
		.y_valid   (y_valid)
	);

	// consumer, serial y burst
	rnn_out_serializer u_serializer (
		.clk       (clk),
		.rst_n     (rst_n),
		.y_valid   (y_valid),
		.y_vec     (y_vec),
		.out_valid (out_valid),
		.out       (out)
	);

endmodule
